/* include/bpm_defines.svh */
`ifndef BPM_DEFINES_SVH
`define BPM_DEFINES_SVH

// channel count and raw sample format
`define BPM_NUM_CH      4
`define BPM_SAMPLE_W    16

// power accumulation
`define BPM_POWER_W     32
`define BPM_SQ_SHIFT    8     // each square is scaled down before it is summed

// abs value that flags a channel as overflowed
`define BPM_OVF_LIMIT   32512

// slow readout packet format
`define BPM_WORD_W      32
`define BPM_EVT_CNT_W   16
`define BPM_PID         32'h4142_504d   // "ABPM"
`define BPM_PKT_WORDS   8

`endif

/* design/bpm_sample_pkg.sv */
`include "bpm_defines.svh"

package bpm_sample_pkg;

	////////////////////////////////////////////////////////////////////////////
	// per channel scalars
	////////////////////////////////////////////////////////////////////////////

	typedef logic signed [`BPM_SAMPLE_W-1:0] adc_sample_t; // two's complement ADC code
	typedef logic [`BPM_POWER_W-1:0] power_t;              // scaled sum of squares
	typedef logic [`BPM_SAMPLE_W-1:0] peak_t;              // abs value, never above 32767

	////////////////////////////////////////////////////////////////////////////
	// bundles on the busses
	////////////////////////////////////////////////////////////////////////////

	// one clock of ADC data, ch A in the top bits
	typedef struct packed {
		adc_sample_t a;
		adc_sample_t b;
		adc_sample_t c;
		adc_sample_t d;
		logic        last; // final sample of the event
	} sample_bus_t;

	typedef struct packed {
		power_t a;
		power_t b;
		power_t c;
		power_t d;
	} power_res_t;

	typedef struct packed {
		peak_t                  a;
		peak_t                  b;
		peak_t                  c;
		peak_t                  d;
		logic [`BPM_NUM_CH-1:0] ovf; // ch A in bit 3 down to ch D in bit 0
	} peak_res_t;

endpackage

/* design/bpm_packet_pkg.sv */
`include "bpm_defines.svh"

package bpm_packet_pkg;

	// one 32 bit slow readout word
	typedef logic [`BPM_WORD_W-1:0] pkt_word_t;

	// packets sent since reset, wraps at 16 bits
	typedef logic [`BPM_EVT_CNT_W-1:0] evt_cnt_t;

	////////////////////////////////////////////////////////////////////////////
	// packer FSM
	////////////////////////////////////////////////////////////////////////////

	// idle waits for both results
	// send walks the 8 words
	typedef enum logic {
		idle = 1'b0,
		send = 1'b1
	} pack_state_t;

	// word order inside one packet
	//   0      packet id
	//   1      ovf bits | zeros | event count
	//   2..5   power A..D
	//   6      peak A | peak B
	//   7      peak C | peak D

endpackage

/* design/channel_power.sv */
`timescale 1ns/10ps
`include "bpm_defines.svh"

module channel_power import bpm_sample_pkg::*; (
	input  logic        clk,
	input  logic        RST_EVENT_NO,
	input  sample_bus_t sample_in,
	input  logic        in_fire,      // sample accepted this cycle
	input  logic        res_take,     // packer grabs the held result
	output power_res_t  power_res,
	output logic        power_valid
);

	// scaled square of one sample
	function automatic power_t sq_term(input adc_sample_t s);
		logic signed [2*`BPM_SAMPLE_W-1:0] sq;
		sq = s * s; // at most 2^30 and never negative
		return power_t'(sq) >> `BPM_SQ_SHIFT;
	endfunction

	adc_sample_t smp [`BPM_NUM_CH]; // channels A..D as an array
	power_t      acc [`BPM_NUM_CH]; // running sums
	power_t      nxt [`BPM_NUM_CH]; // sums including this sample
	logic        first;             // next transfer opens an event

	assign smp[0] = sample_in.a;
	assign smp[1] = sample_in.b;
	assign smp[2] = sample_in.c;
	assign smp[3] = sample_in.d;

	always_comb begin
		for (int i = 0; i < `BPM_NUM_CH; i++) begin
			nxt[i] = (first ? '0 : acc[i]) + sq_term(smp[i]); // wraps mod 2^32
		end
	end

	// running sums of the open event
	always_ff @(posedge clk) begin
		if (in_fire) begin
			for (int i = 0; i < `BPM_NUM_CH; i++) begin
				acc[i] <= nxt[i];
			end
		end
	end

	// finished event lands in the held result
	always_ff @(posedge clk) begin
		if (in_fire && sample_in.last) begin
			power_res.a <= nxt[0];
			power_res.b <= nxt[1];
			power_res.c <= nxt[2];
			power_res.d <= nxt[3];
		end
	end

	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			first       <= 1'b1;
			power_valid <= 1'b0;
		end else begin
			if (in_fire) first <= sample_in.last; // restart after a last
			if (in_fire && sample_in.last) power_valid <= 1'b1;
			else if (res_take) power_valid <= 1'b0;
		end
	end

	// top level stall has to keep an untaken result safe
	a_no_overwrite: assert property (@(posedge clk) disable iff (RST_EVENT_NO)
		!(in_fire && power_valid && !res_take));

endmodule

/* design/peak_detect.sv */
`timescale 1ns/10ps
`include "bpm_defines.svh"

module peak_detect import bpm_sample_pkg::*; (
	input  logic        clk,
	input  logic        RST_EVENT_NO,
	input  sample_bus_t sample_in,
	input  logic        in_fire,
	input  logic        res_take,
	output peak_res_t   peak_res,
	output logic        peak_valid
);

	// abs value, negative full scale clips to 32767
	function automatic peak_t abs_sat(input adc_sample_t s);
		if (s[`BPM_SAMPLE_W-1] && (s[`BPM_SAMPLE_W-2:0] == '0))
			return {1'b0, {(`BPM_SAMPLE_W-1){1'b1}}};
		else if (s[`BPM_SAMPLE_W-1])
			return peak_t'(-s);
		else
			return peak_t'(s);
	endfunction

	adc_sample_t            smp [`BPM_NUM_CH];
	peak_t                  mag [`BPM_NUM_CH]; // abs of this sample
	peak_t                  pk [`BPM_NUM_CH];  // running max
	peak_t                  nxt_pk [`BPM_NUM_CH];
	logic [0:`BPM_NUM_CH-1] ovf;               // sticky, index 0 is ch A
	logic [0:`BPM_NUM_CH-1] nxt_ovf;
	logic [0:`BPM_NUM_CH-1] over_lim;          // held peaks at or above limit
	logic                   first;

	assign smp[0] = sample_in.a;
	assign smp[1] = sample_in.b;
	assign smp[2] = sample_in.c;
	assign smp[3] = sample_in.d;

	always_comb begin
		for (int i = 0; i < `BPM_NUM_CH; i++) begin
			mag[i]     = abs_sat(smp[i]);
			nxt_pk[i]  = (first || (mag[i] > pk[i])) ? mag[i] : pk[i];
			nxt_ovf[i] = (!first && ovf[i]) || (mag[i] >= `BPM_OVF_LIMIT);
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			pk  <= nxt_pk;
			ovf <= nxt_ovf;
		end
		if (in_fire && sample_in.last) begin
			peak_res <= {nxt_pk[0], nxt_pk[1], nxt_pk[2], nxt_pk[3], nxt_ovf}; // A lands in ovf[3]
		end
	end

	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			first      <= 1'b1;
			peak_valid <= 1'b0;
		end else begin
			if (in_fire) first <= sample_in.last;
			if (in_fire && sample_in.last) peak_valid <= 1'b1; // same timing as power
			else if (res_take) peak_valid <= 1'b0;
		end
	end

	assign over_lim[0] = peak_res.a >= `BPM_OVF_LIMIT;
	assign over_lim[1] = peak_res.b >= `BPM_OVF_LIMIT;
	assign over_lim[2] = peak_res.c >= `BPM_OVF_LIMIT;
	assign over_lim[3] = peak_res.d >= `BPM_OVF_LIMIT;

	// a big held peak never shows without its ovf bit
	a_ovf_flag: assert property (@(posedge clk) disable iff (RST_EVENT_NO)
		peak_valid |-> ((over_lim & ~peak_res.ovf) == '0));

endmodule

/* design/event_packer.sv */
`timescale 1ns/10ps
`include "bpm_defines.svh"

module event_packer import bpm_sample_pkg::*, bpm_packet_pkg::*; (
	input  logic       clk,
	input  logic       RST_EVENT_NO,
	input  power_res_t power_res,
	input  logic       power_valid,
	input  peak_res_t  peak_res,
	input  logic       peak_valid,
	output logic       res_take,  // one cycle, loads both results
	output pkt_word_t  pkt_word,
	output logic       out_valid,
	input  logic       out_ready
);

	localparam int idx_w = $clog2(`BPM_PKT_WORDS);
	localparam logic [idx_w-1:0] last_idx = idx_w'(`BPM_PKT_WORDS - 1);

	pack_state_t      state;
	logic [idx_w-1:0] word_idx; // word on the bus
	evt_cnt_t         evt_cnt;  // packets completed so far
	power_res_t       power_q;  // local copy, frees the accumulators
	peak_res_t        peak_q;
	logic             out_fire;
	logic             last_word;

	////////////////////////////////////////////////////////////////////////////
	// handshake
	////////////////////////////////////////////////////////////////////////////

	assign res_take  = (state == idle) && power_valid && peak_valid;
	assign out_valid = (state == send);
	assign out_fire  = out_valid && out_ready;
	assign last_word = (word_idx == last_idx);

	// results for this packet
	always_ff @(posedge clk) begin
		if (res_take) begin
			power_q <= power_res;
			peak_q  <= peak_res;
		end
	end

	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			state    <= idle;
			word_idx <= '0;
			evt_cnt  <= '0;
		end else begin
			case (state)
				idle: begin
					if (res_take) begin
						state    <= send; // word 0 up next cycle
						word_idx <= '0;
					end
				end
				send: begin
					if (out_fire) begin
						if (last_word) begin
							state   <= idle;
							evt_cnt <= evt_cnt + 1'b1; // packet done
						end else begin
							word_idx <= word_idx + 1'b1;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// word mux
	////////////////////////////////////////////////////////////////////////////

	// all inputs are held regs, so a stalled word stays put
	always_comb begin
		case (word_idx)
			3'd0:    pkt_word = `BPM_PID;
			3'd1:    pkt_word = {peak_q.ovf, 12'b0, evt_cnt}; // status | count
			3'd2:    pkt_word = power_q.a;
			3'd3:    pkt_word = power_q.b;
			3'd4:    pkt_word = power_q.c;
			3'd5:    pkt_word = power_q.d;
			3'd6:    pkt_word = {peak_q.a, peak_q.b};
			default: pkt_word = {peak_q.c, peak_q.d};
		endcase
	end

	// stalled word must hold until the sink takes it
	a_hold: assert property (@(posedge clk) disable iff (RST_EVENT_NO)
		out_valid && !out_ready |=> out_valid && $stable(pkt_word));

endmodule

/* design/bpm_event_proc.sv */
`timescale 1ns/10ps

module bpm_event_proc import bpm_sample_pkg::*, bpm_packet_pkg::*; (
	input  logic        clk,
	input  logic        RST_EVENT_NO,
	input  sample_bus_t sample_in,
	input  logic        in_valid,
	output logic        in_ready,
	output pkt_word_t   pkt_word,
	output logic        out_valid,
	input  logic        out_ready
);

	logic       in_fire;
	logic       res_take;
	power_res_t power_res;
	logic       power_valid;
	peak_res_t  peak_res;
	logic       peak_valid;

	// stall only while an untaken result is parked
	assign in_ready = !power_valid || res_take;
	assign in_fire  = in_valid && in_ready;

	////////////////////////////////////////////////////////////////////////////
	// two measurements side by side, then the packer
	////////////////////////////////////////////////////////////////////////////

	channel_power channel_power_inst (
		.clk          (clk),
		.RST_EVENT_NO (RST_EVENT_NO),
		.sample_in    (sample_in),
		.in_fire      (in_fire),
		.res_take     (res_take),
		.power_res    (power_res),
		.power_valid  (power_valid)
	);

	peak_detect peak_detect_inst (
		.clk          (clk),
		.RST_EVENT_NO (RST_EVENT_NO),
		.sample_in    (sample_in),
		.in_fire      (in_fire),
		.res_take     (res_take),
		.peak_res     (peak_res),
		.peak_valid   (peak_valid)
	);

	event_packer event_packer_inst (
		.clk          (clk),
		.RST_EVENT_NO (RST_EVENT_NO),
		.power_res    (power_res),
		.power_valid  (power_valid),
		.peak_res     (peak_res),
		.peak_valid   (peak_valid),
		.res_take     (res_take),
		.pkt_word     (pkt_word),
		.out_valid    (out_valid),
		.out_ready    (out_ready)
	);

	// in_ready looks at power_valid alone, so both flags have to move together
	a_valid_pair: assert property (@(posedge clk) disable iff (RST_EVENT_NO)
		power_valid == peak_valid);

endmodule

/* testbench/tb_bpm_event_proc.sv */
`timescale 1ns/10ps

module tb_bpm_event_proc import bpm_sample_pkg::*, bpm_packet_pkg::*; ();

	localparam int          clk_period = 4;
	localparam int          drive_dly  = 1;          // after the rising edge
	localparam logic [31:0] rng_seed   = 32'd47862;

	logic        clk;
	logic        RST_EVENT_NO;
	sample_bus_t sample_in;
	logic        in_valid;
	logic        in_ready;
	pkt_word_t   pkt_word;
	logic        out_valid;
	logic        out_ready;

	sample_bus_t smp_q [$]; // every sample with repeats expanded
	pkt_word_t   exp_q [$]; // expected words of all packets in a row
	int          errors = 0;
	int          checked = 0;
	int          limit_cycles = 0;
	bit          loaded = 1'b0;
	bit          stim_done = 1'b0;

	bpm_event_proc bpm_event_proc_inst (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus file
	////////////////////////////////////////////////////////////////////////////

	task automatic load_stim();
		int          fd;
		int          cnt;
		int          last;
		string       line;
		adc_sample_t a, b, c, d;
		pkt_word_t   w [8];
		fd = $fopen("testbench/bpm_stim.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open testbench/bpm_stim.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if ($sscanf(line, "S %d %h %h %h %h %d", cnt, a, b, c, d, last) == 6) begin
					for (int i = 0; i < cnt; i++)
						smp_q.push_back({a, b, c, d, ((last != 0) && (i == cnt - 1))});
				end else if ($sscanf(line, "W %h %h %h %h %h %h %h %h", w[0], w[1], w[2],
						w[3], w[4], w[5], w[6], w[7]) == 8) begin
					foreach (w[i]) exp_q.push_back(w[i]);
				end // comments and blank lines fall through
			end
			$fclose(fd);
			if (exp_q.size() == 0) begin
				errors++;
				$display("no expected words found in testbench/bpm_stim.txt");
			end
		end
	endtask

	task automatic check_idle_outputs();
		if (out_valid !== 1'b0) begin
			errors++;
			$display("Error at %0d ns: out_valid expected 0 got %b", $time, out_valid);
		end
		if (in_ready !== 1'b1) begin
			errors++;
			$display("Error at %0d ns: in_ready expected 1 got %b", $time, in_ready);
		end
	endtask

	// word transfers on the coming edge
	task automatic take_word();
		pkt_word_t exp;
		if (exp_q.size() == 0) begin
			errors++;
			$display("unexpected extra word 0x%08h at %0d ns", pkt_word, $time);
		end else begin
			exp = exp_q.pop_front();
			if (pkt_word !== exp) begin
				errors++;
				$display("Error at %0d ns: pkt_word word %0d expected 0x%08h got 0x%08h",
					$time, checked % 8, exp, pkt_word);
			end
			checked++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// processes
	////////////////////////////////////////////////////////////////////////////

	initial begin : clock_gen
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin : main_seq
		RST_EVENT_NO = 1'b1;
		load_stim();
		limit_cycles = (smp_q.size() + exp_q.size()) * 20 + 100;
		loaded = 1'b1;
		repeat (2) @(posedge clk);
		#drive_dly;
		RST_EVENT_NO = 1'b0;
		@(negedge clk);
		check_idle_outputs(); // nothing driven yet
		wait (stim_done && (exp_q.size() == 0));
		repeat (10) @(posedge clk); // room for a stray word
		$display("errors: %0d, words checked: %0d", errors, checked);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin : stim_drive
		int          idx;
		logic        fire;
		logic [31:0] rng;
		sample_in = '0;
		in_valid  = 1'b0;
		idx       = 0;
		fire      = 1'b0;
		rng       = rng_seed;
		wait (!RST_EVENT_NO);
		while (idx < smp_q.size()) begin
			@(posedge clk);
			#drive_dly;
			if (fire) begin
				idx++;
				in_valid = 1'b0;
			end
			rng = xorshift32(rng);
			if (!in_valid && (idx < smp_q.size()) && ((rng % 32'd6) != 32'd0)) begin
				sample_in = smp_q[idx];
				in_valid  = 1'b1;
			end
			@(negedge clk);
			fire = in_valid && in_ready; // stable mid cycle
		end
		stim_done = 1'b1;
	end

	initial begin : out_sink
		logic [31:0] rng;
		out_ready = 1'b0;
		rng       = rng_seed ^ 32'h9e37_79b9; // separate stream from the same generator
		wait (!RST_EVENT_NO);
		forever begin
			@(posedge clk);
			#drive_dly;
			rng       = xorshift32(rng);
			out_ready = (rng % 32'd4) != 32'd0; // stall about one cycle in four
			@(negedge clk);
			if (out_valid && out_ready) take_word();
		end
	end

	initial begin : watchdog
		wait (loaded);
		#(limit_cycles * clk_period);
		$display("timeout after %0d cycles, %0d expected words never arrived",
			limit_cycles, exp_q.size());
		errors += exp_q.size();
		$display("errors: %0d, words checked: %0d", errors, checked);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* bpm_event_proc.f */
+incdir+include
design/bpm_sample_pkg.sv
design/bpm_packet_pkg.sv
design/channel_power.sv
design/peak_detect.sv
design/event_packer.sv
design/bpm_event_proc.sv
testbench/tb_bpm_event_proc.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_bpm_event_proc
FLIST    = bpm_event_proc.f
BUILD    = obj_dir
PASS_MSG = ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD)

/* testbench/bpm_stim.txt */
# S count a b c d last : count copies of one sample, A..D in hex, last flags the final copy only
# W w0 .. w7 : expected packet words in hex, in order
# event 0, one sample, C at negative full scale, D exactly at the limit
S 1 0100 ff00 8000 7f00 1
W 4142504d 30000000 00000100 00000100 00400000 003f0100 01000100 7fff7f00
# event 1, 1025 near full scale samples, A and C wrap past 32 bits
S 1025 7fff 0000 8000 0010 1
W 4142504d a0000001 003bff00 00000000 00400000 00000401 7fff0000 7fff0010
# event 2, negative values, peaks one below the limit
S 1 1000 f000 7eff 8101 0
S 1 e000 0800 0001 0000 1
W 4142504d 00000002 00050000 00014000 003f0002 003f0002 20001000 7eff7eff
# event 3, all zero, right behind event 2 so it meets back-pressure
S 1 0000 0000 0000 0000 1
W 4142504d 00000003 00000000 00000000 00000000 00000000 00000000 00000000
